// File: filelist.f
logic/mxu_pkg.sv
logic/mxu_booth_encoder.sv
logic/mxu_csa_tree.sv
logic/mxu_tag_pipe.sv
logic/mxu_product_pipe.sv
logic/mxu_writeback.sv
logic/mxu_mul.sv
tests/mxu_mul_assert.sv
tests/tb_mxu_mul.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_mxu_mul
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "TEST OK" $(LOG) || (echo "No pass line in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tests/tb_mxu_mul.sv
`timescale 1ns/1ns
`default_nettype none

module tb_mxu_mul;
    import mxu_pkg::*;

    localparam int num_req  = 320;
    localparam int lat_cyc  = 5;

    typedef struct packed {
        mul_resp_t exp_resp;
        int        edge_no;   // Acceptance edge
    } exp_entry_t;

    logic       clk;
    logic       rst_clk;
    logic       flush;
    mul_req_t   req;
    mul_resp_t  resp;
    fwd_t       fwd1;
    fwd_t       fwd2;

    exp_entry_t exp_q [$];
    exp_entry_t ent;
    fwd_t       fwd_hist [3];
    int         edge_cnt;
    logic [4:0] next_iid;
    logic [31:0] r1;
    logic [31:0] r2;

    mxu_mul i_mxu_mul (
        .clk     (clk),
        .rst_clk (rst_clk),
        .flush   (flush),
        .req     (req),
        .resp    (resp),
        .fwd1    (fwd1),
        .fwd2    (fwd2)
    );

    always #20 clk = ~clk;

    task automatic abort_run();
        $display("TEST FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic report_error(input string msg);
        $display("ERROR @%0t: %s", $time, msg);
        abort_run();
    endtask

    // ------------------------------------------------------------
    // Expected values
    // ------------------------------------------------------------
    function automatic logic [63:0] ref_result(input logic [63:0] a, input logic [63:0] b,
                                               input logic [6:0] opcode, input logic [2:0] f3);
        logic         op64;
        logic [63:0]  wa;
        logic [63:0]  wb;
        logic [127:0] xa;
        logic [127:0] xb;
        logic [127:0] prod;
        logic [63:0]  half;
        op64 = (opcode == opc_op);
        wa   = op64 ? a : {{32{a[31]}}, a[31:0]};
        wb   = op64 ? b : {{32{b[31]}}, b[31:0]};
        xa   = (f3[1:0] == 2'b11) ? {64'd0, wa} : {{64{wa[63]}}, wa};   // MULHU unsigned
        xb   = f3[1] ? {64'd0, wb} : {{64{wb[63]}}, wb};                // MULHSU, MULHU
        prod = xa * xb;
        half = (f3[1:0] == 2'b00) ? prod[63:0] : prod[127:64];
        return op64 ? half : {{32{half[31]}}, half[31:0]};
    endfunction

    function automatic logic [63:0] rand_operand();
        logic [31:0] sel;
        sel = $urandom % 8;
        case (sel)
            0:       return 64'd0;
            1:       return '1;
            2:       return 64'h8000_0000_0000_0000;
            3:       return 64'h0000_0000_8000_0000;
            4:       return 64'h0000_0000_ffff_ffff;
            default: return {$urandom, $urandom};
        endcase
    endfunction

    task automatic check_resp(input mul_resp_t got, input mul_resp_t exp);
        if (got !== exp) begin
            report_error($sformatf("resp iid %0d data %h wb %b/%0d, exp iid %0d data %h wb %b/%0d",
                got.iid, got.wb_data, got.wb_vld, got.wb_preg,
                exp.iid, exp.wb_data, exp.wb_vld, exp.wb_preg));
        end
    endtask

    task automatic check_fwd(input string name, input fwd_t got, input fwd_t exp);
        if (got.valid !== exp.valid || (exp.valid && got.preg !== exp.preg)) begin
            report_error($sformatf("%s valid %b preg %0d, expected valid %b preg %0d",
                name, got.valid, got.preg, exp.valid, exp.preg));
        end
    endtask

    task automatic check_latency(input int got, input int exp);
        if (got != exp) begin
            report_error($sformatf("latency %0d cycles, expected %0d", got, exp));
        end
    endtask

    // ------------------------------------------------------------
    // Scoreboard
    // ------------------------------------------------------------
    always @(posedge clk) begin
        edge_cnt = edge_cnt + 1;
        if (rst_clk) begin
            fwd_hist[2] = fwd_hist[1];
            fwd_hist[1] = fwd_hist[0];
            fwd_hist[0] = '0;
            if (flush) begin
                exp_q.delete();   // Everything in flight dies
                fwd_hist[1] = '0;
                fwd_hist[2] = '0;
            end else if (req.valid && !req.funct3[2]) begin
                fwd_hist[0].valid   = (req.pdst != '0);
                fwd_hist[0].preg    = req.pdst;
                ent.exp_resp.complete = 1'b1;
                ent.exp_resp.iid      = req.iid;
                ent.exp_resp.wb_vld   = (req.pdst != '0);
                ent.exp_resp.wb_preg  = req.pdst;
                ent.exp_resp.wb_data  = ref_result(req.src1, req.src2, req.opcode, req.funct3);
                ent.edge_no           = edge_cnt;
                exp_q.push_back(ent);
            end
        end
    end

    always @(negedge clk) begin
        if (rst_clk) begin
            check_fwd("fwd1", fwd1, fwd_hist[1]);
            check_fwd("fwd2", fwd2, fwd_hist[2]);
            if (resp.complete) begin
                if (exp_q.size() == 0) begin
                    $display("Completion with iid %0d while nothing was expected", resp.iid);
                    abort_run();
                end else begin
                    ent = exp_q.pop_front();
                    check_latency(edge_cnt - ent.edge_no + 1, lat_cyc);
                    check_resp(resp, ent.exp_resp);
                end
            end
        end
    end

    initial begin
        #((num_req + 50) * 40);
        $display("Timeout: the run did not finish in time");
        abort_run();
    end

    // ------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------
    initial begin
        void'($urandom(32'h447f));
        clk      = 1'b0;
        rst_clk  = 1'b1;
        flush    = 1'b0;
        req      = '0;
        edge_cnt = 0;
        next_iid = '0;
        fwd_hist[0] = '0;
        fwd_hist[1] = '0;
        fwd_hist[2] = '0;
        #1 rst_clk = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_clk = 1'b1;
        for (int i = 0; i < num_req; i++) begin
            r1 = $urandom % 8;
            r2 = $urandom;
            req.valid  = (r1 != 0);
            req.iid    = next_iid;
            req.opcode = (r2[9:8] == 2'd0) ? opc_op32 : opc_op;
            req.funct3 = {(r2[7:4] == 4'd0), (r2[9:8] == 2'd0) ? 2'b00 : r2[1:0]};
            req.src1   = rand_operand();
            req.src2   = rand_operand();
            req.pdst   = (r2[15:12] == 4'd0) ? 6'd0 : r2[21:16];
            flush      = (i % 61 == 40);
            next_iid   = next_iid + 5'd1;
            @(negedge clk);
        end
        req.valid = 1'b0;
        flush     = 1'b0;
        repeat (10) @(negedge clk);
        if (exp_q.size() != 0) begin
            $display("%0d accepted requests never completed", exp_q.size());
            abort_run();
        end else begin
            $display("TEST OK");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: tests/mxu_mul_assert.sv
`timescale 1ns/1ns
`default_nettype none

module mxu_mul_assert (
    input logic               clk,
    input logic               rst_clk,
    input logic               flush,
    input mxu_pkg::mul_resp_t resp,
    input mxu_pkg::fwd_t      fwd1,
    input mxu_pkg::fwd_t      fwd2
);
    import mxu_pkg::*;

    a_wb_needs_complete: assert property (@(posedge clk) disable iff (!rst_clk)
        resp.wb_vld |-> resp.complete)
        else $error("wb_vld without complete");

    // Flush edge empties stage 4 too
    a_flush_kills: assert property (@(posedge clk) disable iff (!rst_clk)
        flush |=> !resp.complete)
        else $error("completion right after flush");

    a_fwd1_preg: assert property (@(posedge clk) disable iff (!rst_clk)
        fwd1.valid |-> (fwd1.preg != '0))
        else $error("fwd1 reports x0");

    a_reset_quiet: assert property (@(posedge clk)
        !rst_clk |-> !(resp.complete | resp.wb_vld | fwd1.valid | fwd2.valid))
        else $error("valid output during reset");

endmodule

bind mxu_mul mxu_mul_assert i_mxu_mul_assert (
    .clk     (clk),
    .rst_clk (rst_clk),
    .flush   (flush),
    .resp    (resp),
    .fwd1    (fwd1),
    .fwd2    (fwd2)
);

`default_nettype wire

// File: logic/mxu_mul.sv
`timescale 1ns/1ns
`default_nettype none

module mxu_mul (
    input  logic                clk,
    input  logic                rst_clk,
    input  logic                flush,
    input  mxu_pkg::mul_req_t   req,
    output mxu_pkg::mul_resp_t  resp,
    output mxu_pkg::fwd_t       fwd1,
    output mxu_pkg::fwd_t       fwd2
);
    import mxu_pkg::*;

    mul_ctrl_t       ctrl;
    mul_tag_t        tag3;
    mul_tag_t        tag4;
    logic [xlen-1:0] sum_lo;
    logic            carry_lo;
    logic [xlen-1:0] row0_hi;
    logic [xlen-1:0] row1_hi;
    logic [xlen-1:0] wb_data;

    mxu_tag_pipe i_tag_pipe (
        .clk     (clk),
        .rst_clk (rst_clk),
        .flush   (flush),
        .req     (req),
        .ctrl    (ctrl),
        .tag3    (tag3),
        .tag4    (tag4),
        .fwd1    (fwd1),
        .fwd2    (fwd2)
    );

    mxu_product_pipe i_product_pipe (
        .clk      (clk),
        .rst_clk  (rst_clk),
        .req      (req),
        .ctrl     (ctrl),
        .sum_lo   (sum_lo),
        .carry_lo (carry_lo),
        .row0_hi  (row0_hi),
        .row1_hi  (row1_hi)
    );

    mxu_writeback i_writeback (
        .clk      (clk),
        .rst_clk  (rst_clk),
        .tag3     (tag3),
        .sum_lo   (sum_lo),
        .carry_lo (carry_lo),
        .row0_hi  (row0_hi),
        .row1_hi  (row1_hi),
        .wb_data  (wb_data)
    );

    // x0 is never written back
    always_comb begin
        resp.complete = tag4.valid;
        resp.iid      = tag4.iid;
        resp.wb_vld   = tag4.valid & (tag4.pdst != '0);
        resp.wb_preg  = tag4.pdst;
        resp.wb_data  = wb_data;
    end

endmodule

`default_nettype wire

// File: logic/mxu_writeback.sv
`timescale 1ns/1ns
`default_nettype none

module mxu_writeback (
    input  logic                     clk,
    input  logic                     rst_clk,
    input  mxu_pkg::mul_tag_t        tag3,
    input  logic [mxu_pkg::xlen-1:0] sum_lo,
    input  logic                     carry_lo,
    input  logic [mxu_pkg::xlen-1:0] row0_hi,
    input  logic [mxu_pkg::xlen-1:0] row1_hi,
    output logic [mxu_pkg::xlen-1:0] wb_data
);
    import mxu_pkg::*;

    logic [xlen-1:0] sum_hi;
    logic [xlen-1:0] half;
    logic [xlen-1:0] result;

    assign sum_hi = row0_hi + row1_hi + {{(xlen-1){1'b0}}, carry_lo};
    assign half   = tag3.hi_sel ? sum_hi : sum_lo;

    // MULW result is the low word, sign extended
    assign result = tag3.op64 ? half : {{32{half[31]}}, half[31:0]};

    always_ff @(posedge clk or negedge rst_clk) begin
        if (!rst_clk) begin
            wb_data <= '0;
        end else begin
            wb_data <= result;
        end
    end

endmodule

`default_nettype wire

// File: logic/mxu_product_pipe.sv
`timescale 1ns/1ns
`default_nettype none

module mxu_product_pipe (
    input  logic                     clk,
    input  logic                     rst_clk,
    input  mxu_pkg::mul_req_t        req,
    input  mxu_pkg::mul_ctrl_t       ctrl,
    output logic [mxu_pkg::xlen-1:0] sum_lo,
    output logic                     carry_lo,
    output logic [mxu_pkg::xlen-1:0] row0_hi,
    output logic [mxu_pkg::xlen-1:0] row1_hi
);
    import mxu_pkg::*;

    logic [xlen-1:0]   src1_s0;
    logic [xlen-1:0]   src2_s0;
    mul_ctrl_t         ctrl_s0;
    logic [pp_w-1:0]   pp      [num_pp];
    logic [pp_w-1:0]   pp_s1   [num_pp];
    logic [prod_w-1:0] row0;
    logic [prod_w-1:0] row1;
    logic [prod_w-1:0] row0_s2;
    logic [prod_w-1:0] row1_s2;

    always_ff @(posedge clk or negedge rst_clk) begin
        if (!rst_clk) begin
            ctrl_s0 <= '0;
        end else begin
            ctrl_s0 <= ctrl;
        end
    end

    // ------------------------------------------------------------
    // Datapath registers, stages 0 to 3
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        src1_s0 <= req.src1;
        src2_s0 <= req.src2;
        pp_s1   <= pp;
        row0_s2 <= row0;
        row1_s2 <= row1;
        // Low half of the final add, carry goes to writeback
        {carry_lo, sum_lo} <= {1'b0, row0_s2[xlen-1:0]} + {1'b0, row1_s2[xlen-1:0]};
        row0_hi <= row0_s2[prod_w-1:xlen];
        row1_hi <= row1_s2[prod_w-1:xlen];
    end

    mxu_booth_encoder i_booth (
        .src1 (src1_s0),
        .src2 (src2_s0),
        .ctrl (ctrl_s0),
        .pp   (pp)
    );

    mxu_csa_tree i_csa (
        .pp   (pp_s1),
        .row0 (row0),
        .row1 (row1)
    );

endmodule

`default_nettype wire

// File: logic/mxu_tag_pipe.sv
`timescale 1ns/1ns
`default_nettype none

module mxu_tag_pipe (
    input  logic               clk,
    input  logic               rst_clk,
    input  logic               flush,
    input  mxu_pkg::mul_req_t  req,
    output mxu_pkg::mul_ctrl_t ctrl,
    output mxu_pkg::mul_tag_t  tag3,
    output mxu_pkg::mul_tag_t  tag4,
    output mxu_pkg::fwd_t      fwd1,
    output mxu_pkg::fwd_t      fwd2
);
    import mxu_pkg::*;

    logic     accept;
    mul_tag_t tag_in;
    mul_tag_t tag_q [5];   // Stages 0 to 4

    // Divide and remainder share the issue port but are not ours
    assign accept = req.valid & ~req.funct3[2] & ~flush;

    always_comb begin
        ctrl.op64   = (req.opcode == opc_op);
        ctrl.sign_x = (req.funct3[1:0] != 2'b11);   // MULHU only
        ctrl.sign_y = ~req.funct3[1];
    end

    always_comb begin
        tag_in.valid  = accept;
        tag_in.iid    = req.iid;
        tag_in.pdst   = req.pdst;
        tag_in.hi_sel = (req.funct3[1:0] != 2'b00);
        tag_in.op64   = ctrl.op64;
    end

    // ------------------------------------------------------------
    // Tag shift register
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_clk) begin
        if (!rst_clk) begin
            for (int i = 0; i < 5; i++) begin
                tag_q[i] <= '0;
            end
        end else begin
            tag_q[0] <= tag_in;
            for (int i = 1; i < 5; i++) begin
                tag_q[i] <= tag_q[i-1];
            end
            if (flush) begin
                for (int i = 0; i < 5; i++) begin
                    tag_q[i].valid <= 1'b0;   // Kill everything in flight
                end
            end
        end
    end

    always_comb begin
        fwd1.valid = tag_q[1].valid & (tag_q[1].pdst != '0);
        fwd1.preg  = tag_q[1].pdst;
        fwd2.valid = tag_q[2].valid & (tag_q[2].pdst != '0);
        fwd2.preg  = tag_q[2].pdst;
    end

    assign tag3 = tag_q[3];
    assign tag4 = tag_q[4];

endmodule

`default_nettype wire

// File: logic/mxu_csa_tree.sv
`timescale 1ns/1ns
`default_nettype none

module mxu_csa_tree (
    input  logic [mxu_pkg::pp_w-1:0]   pp [mxu_pkg::num_pp],
    output logic [mxu_pkg::prod_w-1:0] row0,
    output logic [mxu_pkg::prod_w-1:0] row1
);
    import mxu_pkg::*;

    // Row count entering a given layer
    function automatic int rows_at(input int lvl);
        int n;
        n = num_pp;
        for (int k = 0; k < lvl; k++) begin
            n = 2 * (n / 3) + n % 3;
        end
        return n;
    endfunction

    logic [pp_w-1:0] row [csa_lvl+1][num_pp];

    for (genvar g = 0; g < num_pp; g++) begin : g_in
        assign row[0][g] = pp[g];
    end

    // ------------------------------------------------------------
    // 3:2 layers, leftover rows pass straight down
    // ------------------------------------------------------------
    for (genvar l = 0; l < csa_lvl; l++) begin : g_lvl
        for (genvar g = 0; g < rows_at(l) / 3; g++) begin : g_csa
            assign row[l+1][2*g]   = row[l][3*g] ^ row[l][3*g+1] ^ row[l][3*g+2];
            assign row[l+1][2*g+1] = ((row[l][3*g] & row[l][3*g+1])
                                    | (row[l][3*g] & row[l][3*g+2])
                                    | (row[l][3*g+1] & row[l][3*g+2])) << 1;
        end
        for (genvar r = 0; r < rows_at(l) % 3; r++) begin : g_pass
            assign row[l+1][2*(rows_at(l)/3)+r] = row[l][3*(rows_at(l)/3)+r];
        end
    end

    assign row0 = row[csa_lvl][0][prod_w-1:0];
    assign row1 = row[csa_lvl][1][prod_w-1:0];

endmodule

`default_nettype wire

// File: logic/mxu_booth_encoder.sv
`timescale 1ns/1ns
`default_nettype none

module mxu_booth_encoder (
    input  logic [mxu_pkg::xlen-1:0] src1,
    input  logic [mxu_pkg::xlen-1:0] src2,
    input  mxu_pkg::mul_ctrl_t       ctrl,
    output logic [mxu_pkg::pp_w-1:0] pp [mxu_pkg::num_pp]
);
    import mxu_pkg::*;

    logic [xlen-1:0]  op1;
    logic [xlen-1:0]  op2;
    logic [ext_w-1:0] x;
    logic [ext_w-1:0] y;
    logic [ext_w:0]   y_ext;   // Implicit zero below bit 0
    logic [ext_w:0]   x1;
    logic [ext_w:0]   x2;

    // Word ops take the low words sign extended
    assign op1 = ctrl.op64 ? src1 : {{32{src1[31]}}, src1[31:0]};
    assign op2 = ctrl.op64 ? src2 : {{32{src2[31]}}, src2[31:0]};

    assign x = ctrl.sign_x ? {{2{op1[xlen-1]}}, op1} : {2'b00, op1};
    assign y = ctrl.sign_y ? {{2{op2[xlen-1]}}, op2} : {2'b00, op2};

    assign y_ext = {y, 1'b0};
    assign x1    = {x[ext_w-1], x};
    assign x2    = {x, 1'b0};

    // ------------------------------------------------------------
    // Radix-4 recoding, one partial product per bit pair of y
    // ------------------------------------------------------------
    for (genvar g = 0; g < num_pp; g++) begin : g_pp
        logic [2:0]     grp;
        logic [ext_w:0] mult;

        assign grp = y_ext[2*g+2 -: 3];

        always_comb begin
            case (grp)
                3'b001, 3'b010: mult = x1;
                3'b011:         mult = x2;
                3'b100:         mult = ~x2 + 1'b1;
                3'b101, 3'b110: mult = ~x1 + 1'b1;
                default:        mult = '0;   // 000 and 111
            endcase
        end

        assign pp[g] = {{(pp_w-ext_w-1){mult[ext_w]}}, mult} << (2*g);
    end

endmodule

`default_nettype wire

// File: logic/mxu_pkg.sv
`default_nettype none

package mxu_pkg;

    // ------------------------------------------------------------
    // Widths and counts
    // ------------------------------------------------------------
    localparam int xlen    = 64;
    localparam int iid_w   = 5;
    localparam int preg_w  = 6;
    localparam int ext_w   = 66;   // 64 bits plus two sign bits
    localparam int num_pp  = 33;   // ext_w / 2 Booth groups
    localparam int pp_w    = 132;
    localparam int prod_w  = 128;
    localparam int csa_lvl = 8;    // 3:2 layers from 33 rows down to 2

    localparam logic [6:0] opc_op   = 7'b0110011;
    localparam logic [6:0] opc_op32 = 7'b0111011;

    // ------------------------------------------------------------
    // Types
    // ------------------------------------------------------------
    typedef struct packed {
        logic              valid;
        logic [iid_w-1:0]  iid;
        logic [6:0]        opcode;
        logic [2:0]        funct3;
        logic [xlen-1:0]   src1;
        logic [xlen-1:0]   src2;
        logic [preg_w-1:0] pdst;
    } mul_req_t;

    typedef struct packed {
        logic op64;
        logic sign_x;
        logic sign_y;
    } mul_ctrl_t;

    typedef struct packed {
        logic              valid;
        logic [iid_w-1:0]  iid;
        logic [preg_w-1:0] pdst;
        logic              hi_sel;   // Upper half of the product
        logic              op64;
    } mul_tag_t;

    typedef struct packed {
        logic              valid;
        logic [preg_w-1:0] preg;
    } fwd_t;

    typedef struct packed {
        logic              complete;
        logic [iid_w-1:0]  iid;
        logic              wb_vld;
        logic [preg_w-1:0] wb_preg;
        logic [xlen-1:0]   wb_data;
    } mul_resp_t;

endpackage

`default_nettype wire
